// File: source/sample_pkg.sv
`default_nettype none

package sample_pkg;

  // Raw unsigned input sample
  typedef logic [7:0] sample_t;

  localparam int WINDOW_LEN = 5;

  // Enough bits to count up to a full window
  typedef logic [$clog2(WINDOW_LEN + 1) - 1:0] fill_cnt_t;

  // Five-sample sliding window with s1 oldest and s5 newest
  typedef struct packed {
    sample_t s1;
    sample_t s2;
    sample_t s3;  // Centre
    sample_t s4;
    sample_t s5;
  } window_t;

endpackage

`default_nettype wire

// File: source/order_pkg.sv
`default_nettype none

package order_pkg;

  // Register stages between sorter input and output
  localparam int SORT_LATENCY = 3;

  // Window in ascending order
  typedef struct packed {
    sample_pkg::sample_t rank0;  // Minimum
    sample_pkg::sample_t rank1;
    sample_pkg::sample_t rank2;  // Median
    sample_pkg::sample_t rank3;
    sample_pkg::sample_t rank4;  // Maximum
  } ranked_t;

  // Filter output sample and whether it was substituted
  typedef struct packed {
    sample_pkg::sample_t sample;
    logic                replaced;
  } filter_out_t;

endpackage

`default_nettype wire

// File: source/sorting_network.sv
`timescale 1ns/1ps
`default_nettype none

module sorting_network (
  input  sample_pkg::sample_t s1_i,
  input  sample_pkg::sample_t s2_i,
  input  sample_pkg::sample_t s3_i,
  output sample_pkg::sample_t max_o,
  output sample_pkg::sample_t med_o,
  output sample_pkg::sample_t min_o
);

  sample_pkg::sample_t hi_a, lo_a;
  sample_pkg::sample_t hi_b, lo_b;

  always_comb begin
    // Order s1 and s2
    hi_a = (s1_i > s2_i) ? s1_i : s2_i;
    lo_a = (s1_i > s2_i) ? s2_i : s1_i;

    // Bring s3 in against the larger one
    hi_b = (hi_a > s3_i) ? hi_a : s3_i;
    lo_b = (hi_a > s3_i) ? s3_i : hi_a;

    // Final swap sorts the two lower values
    max_o = hi_b;
    med_o = (lo_a > lo_b) ? lo_a : lo_b;
    min_o = (lo_a > lo_b) ? lo_b : lo_a;
  end

endmodule

`default_nettype wire

// File: source/sort_ascending_5.sv
`timescale 1ns/1ps
`default_nettype none

module sort_ascending_5 (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                done_i,
  input  sample_pkg::window_t window_i,
  output logic                done_o,
  output order_pkg::ranked_t  sorted_o
);

  typedef struct packed {
    sample_pkg::sample_t max;
    sample_pkg::sample_t med;
    sample_pkg::sample_t min;
    sample_pkg::sample_t s4;
    sample_pkg::sample_t s5;
  } stage1_t;

  typedef struct packed {
    sample_pkg::sample_t max;  // Overall maximum
    sample_pkg::sample_t med;
    sample_pkg::sample_t min;
    sample_pkg::sample_t med1;
    sample_pkg::sample_t min1;
  } stage2_t;

  typedef struct packed {
    sample_pkg::sample_t max;  // Second largest
    sample_pkg::sample_t med;
    sample_pkg::sample_t min;
    sample_pkg::sample_t min1;
    sample_pkg::sample_t max_o;
  } stage3_t;

  stage1_t p1;
  stage2_t p2;
  stage3_t p3;
  logic [2:0] done_q;  // One bit per stage

  sample_pkg::sample_t sn1_max, sn1_med, sn1_min;
  sample_pkg::sample_t sn2_max, sn2_med, sn2_min;
  sample_pkg::sample_t sn3_max, sn3_med, sn3_min;
  sample_pkg::sample_t sn4_max, sn4_med, sn4_min;

  // Oldest three samples
  sorting_network u_sn1 (
    .s1_i  (window_i.s1),
    .s2_i  (window_i.s2),
    .s3_i  (window_i.s3),
    .max_o (sn1_max),
    .med_o (sn1_med),
    .min_o (sn1_min)
  );

  // Largest of the first three against the two newest
  sorting_network u_sn2 (
    .s1_i  (p1.max),
    .s2_i  (p1.s4),
    .s3_i  (p1.s5),
    .max_o (sn2_max),
    .med_o (sn2_med),
    .min_o (sn2_min)
  );

  sorting_network u_sn3 (
    .s1_i  (p2.med1),
    .s2_i  (p2.med),
    .s3_i  (p2.min),
    .max_o (sn3_max),
    .med_o (sn3_med),
    .min_o (sn3_min)
  );

  // Lowest three values left over
  sorting_network u_sn4 (
    .s1_i  (p3.min1),
    .s2_i  (p3.med),
    .s3_i  (p3.min),
    .max_o (sn4_max),
    .med_o (sn4_med),
    .min_o (sn4_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1     <= '0;
      p2     <= '0;
      p3     <= '0;
      done_q <= '0;
    end else begin
      p1     <= '{max: sn1_max, med: sn1_med, min: sn1_min, s4: window_i.s4, s5: window_i.s5};
      p2     <= '{max: sn2_max, med: sn2_med, min: sn2_min, med1: p1.med, min1: p1.min};
      p3     <= '{max: sn3_max, med: sn3_med, min: sn3_min, min1: p2.min1, max_o: p2.max};
      done_q <= {done_q[1:0], done_i};
    end
  end

  assign sorted_o = '{rank0: sn4_min, rank1: sn4_med, rank2: sn4_max,
                      rank3: p3.max, rank4: p3.max_o};
  assign done_o   = done_q[2];

  // Every window leaving the sorter must be in order
  a_sorted_order: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> (sorted_o.rank0 <= sorted_o.rank1) && (sorted_o.rank1 <= sorted_o.rank2) &&
               (sorted_o.rank2 <= sorted_o.rank3) && (sorted_o.rank3 <= sorted_o.rank4));

endmodule

`default_nettype wire

// File: source/sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module sample_window (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::sample_t sample_i,
  input  logic                sample_valid_i,
  output sample_pkg::window_t window_o,
  output logic                window_valid_o
);

  sample_pkg::fill_cnt_t fill_cnt;
  logic                  window_full;

  // True once this strobe completes the first full window
  assign window_full = (fill_cnt >= sample_pkg::fill_cnt_t'(sample_pkg::WINDOW_LEN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window_o       <= '0;
      fill_cnt       <= '0;
      window_valid_o <= 1'b0;
    end else begin
      window_valid_o <= sample_valid_i && window_full;
      if (sample_valid_i) begin
        window_o <= '{s1: window_o.s2, s2: window_o.s3, s3: window_o.s4,
                      s4: window_o.s5, s5: sample_i};
        if (fill_cnt != sample_pkg::fill_cnt_t'(sample_pkg::WINDOW_LEN))
          fill_cnt <= fill_cnt + 1'b1;  // Saturates at a full window
      end
    end
  end

  // A window is only issued once it has been filled
  a_window_filled: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(window_valid_o) |->
      (fill_cnt == sample_pkg::fill_cnt_t'(sample_pkg::WINDOW_LEN)));

endmodule

`default_nettype wire

// File: source/center_delay.sv
`timescale 1ns/1ps
`default_nettype none

module center_delay (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::sample_t center_i,
  input  logic                valid_i,
  output sample_pkg::sample_t center_o,
  output logic                center_valid_o
);

  sample_pkg::sample_t                  center_q [order_pkg::SORT_LATENCY];
  logic [order_pkg::SORT_LATENCY - 1:0] valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < order_pkg::SORT_LATENCY; i++)
        center_q[i] <= '0;
      valid_q <= '0;
    end else begin
      center_q[0] <= center_i;
      for (int i = 1; i < order_pkg::SORT_LATENCY; i++)
        center_q[i] <= center_q[i - 1];
      valid_q <= {valid_q[order_pkg::SORT_LATENCY - 2:0], valid_i};
    end
  end

  assign center_o       = center_q[order_pkg::SORT_LATENCY - 1];
  assign center_valid_o = valid_q[order_pkg::SORT_LATENCY - 1];

endmodule

`default_nettype wire

// File: source/impulse_replace.sv
`timescale 1ns/1ps
`default_nettype none

module impulse_replace #(
  parameter int unsigned SPREAD_MIN = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  order_pkg::ranked_t     sorted_i,
  input  logic                   sorted_valid_i,
  input  sample_pkg::sample_t    center_i,
  input  logic                   center_valid_i,
  output order_pkg::filter_out_t result_o,
  output logic                   result_valid_o
);

  sample_pkg::sample_t spread;
  logic                at_extreme;
  logic                is_impulse;

  // Never negative since rank4 >= rank0
  assign spread     = sorted_i.rank4 - sorted_i.rank0;
  assign at_extreme = (center_i == sorted_i.rank0) || (center_i == sorted_i.rank4);
  assign is_impulse = at_extreme && (32'(spread) > SPREAD_MIN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_o       <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= sorted_valid_i;
      if (is_impulse)
        result_o <= '{sample: sorted_i.rank2, replaced: 1'b1};  // Swap in the median
      else
        result_o <= '{sample: center_i, replaced: 1'b0};
    end
  end

  // Sorter and centre delay must stay in step
  a_paths_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    sorted_valid_i == center_valid_i);

endmodule

`default_nettype wire

// File: source/median_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module median_filter_top #(
  parameter int unsigned SPREAD_MIN = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sample_pkg::sample_t    sample_i,
  input  logic                   sample_valid_i,
  output order_pkg::filter_out_t result_o,
  output logic                   result_valid_o
);

  sample_pkg::window_t window;
  logic                window_valid;
  order_pkg::ranked_t  sorted;
  logic                sorted_valid;
  sample_pkg::sample_t center;
  logic                center_valid;

  sample_window u_window (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .window_o       (window),
    .window_valid_o (window_valid)
  );

  sort_ascending_5 u_sort (
    .clk      (clk),
    .rst_n    (rst_n),
    .done_i   (window_valid),
    .window_i (window),
    .done_o   (sorted_valid),
    .sorted_o (sorted)
  );

  // Centre travels beside the sorter
  center_delay u_center (
    .clk            (clk),
    .rst_n          (rst_n),
    .center_i       (window.s3),
    .valid_i        (window_valid),
    .center_o       (center),
    .center_valid_o (center_valid)
  );

  impulse_replace #(
    .SPREAD_MIN (SPREAD_MIN)
  ) u_replace (
    .clk            (clk),
    .rst_n          (rst_n),
    .sorted_i       (sorted),
    .sorted_valid_i (sorted_valid),
    .center_i       (center),
    .center_valid_i (center_valid),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

`default_nettype wire

// File: tb/median_checker.sv
`timescale 1ns/1ps
`default_nettype none

module median_checker #(
  parameter int unsigned SPREAD_MIN = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sample_pkg::sample_t    sample_i,
  input  logic                   sample_valid_i,
  input  order_pkg::filter_out_t result_i,
  input  logic                   result_valid_i,
  output int                     pass_count_o,
  output int                     fail_count_o,
  output int                     pending_o
);

  localparam int LATENCY = 5;  // Sample strobe to result strobe

  typedef struct packed {
    order_pkg::filter_out_t value;
    logic [31:0]            due;
  } expect_t;

  expect_t                pending_q[$];
  order_pkg::filter_out_t table_q[$];  // Hand-written results from the table
  sample_pkg::sample_t    win [sample_pkg::WINDOW_LEN];  // win[0] oldest
  int                     fill = 0;
  int                     cycle = 0;

  initial begin
    pass_count_o = 0;
    fail_count_o = 0;
    pending_o    = 0;
  end

  task automatic expect_result(input sample_pkg::sample_t value, input logic replaced);
    table_q.push_back('{sample: value, replaced: replaced});
  endtask

  // Median when the centre is an impulse, the centre itself otherwise
  function automatic order_pkg::filter_out_t predict();
    sample_pkg::sample_t s [sample_pkg::WINDOW_LEN];
    sample_pkg::sample_t tmp;
    sample_pkg::sample_t centre;
    s      = win;
    centre = win[2];
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4 - i; j++) begin
        if (s[j] > s[j + 1]) begin
          tmp      = s[j];
          s[j]     = s[j + 1];
          s[j + 1] = tmp;
        end
      end
    end
    if ((centre == s[0] || centre == s[4]) && int'(s[4]) - int'(s[0]) > int'(SPREAD_MIN))
      return '{sample: s[2], replaced: 1'b1};
    return '{sample: centre, replaced: 1'b0};
  endfunction

  always @(posedge clk) begin
    order_pkg::filter_out_t want;
    expect_t                head;
    cycle++;
    if (!rst_n) begin
      fill = 0;
    end else if (sample_valid_i) begin
      for (int i = 0; i < sample_pkg::WINDOW_LEN - 1; i++)
        win[i] = win[i + 1];
      win[sample_pkg::WINDOW_LEN - 1] = sample_i;
      if (fill < sample_pkg::WINDOW_LEN)
        fill++;
      if (fill == sample_pkg::WINDOW_LEN) begin
        want = predict();
        if (table_q.size() > 0)
          want = table_q.pop_front();  // Table value takes over in the directed phase
        pending_q.push_back('{value: want, due: 32'(cycle + LATENCY)});
      end
    end
    // Output strobe before the first edge is still unknown
    if (cycle > 1) begin
      if (pending_q.size() > 0 && pending_q[0].due == 32'(cycle)) begin
        head = pending_q.pop_front();
        if (result_valid_i !== 1'b1) begin
          $display("Missing result at %0t: no output strobe five cycles after its sample", $time);
          fail_count_o++;
        end else if (result_i !== head.value) begin
          $display("FAILED t=%0t: got %0d replaced=%0b, expected %0d replaced=%0b", $time,
                   result_i.sample, result_i.replaced, head.value.sample, head.value.replaced);
          fail_count_o++;
        end else begin
          $display("ok t=%0t: %0d replaced=%0b", $time, result_i.sample, result_i.replaced);
          pass_count_o++;
        end
      end else if (result_valid_i !== 1'b0) begin
        $display("Unexpected result strobe at %0t with no window due", $time);
        fail_count_o++;
      end
    end
    pending_o = pending_q.size();
  end

endmodule

`default_nettype wire

// File: tb/tb_median_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_median_filter;

  localparam int unsigned SPREAD_MIN = 16;
  localparam int TABLE_LEN    = 21;
  localparam int RANDOM_COUNT = 200;
  localparam int EXPECTED     = TABLE_LEN - (sample_pkg::WINDOW_LEN - 1) + RANDOM_COUNT;

  // Sample, idle cycles after it, expected result and replaced flag
  typedef struct packed {
    sample_pkg::sample_t sample;
    logic [3:0]          idle;
    sample_pkg::sample_t want;
    logic                replaced;
  } entry_t;

  // Spike, flat peak, ramp with gaps, then a low spike
  localparam entry_t STIM [TABLE_LEN] = '{
    '{8'd10, 4'd0, 8'd0, 1'b0},   '{8'd12, 4'd0, 8'd0, 1'b0},    '{8'd250, 4'd0, 8'd0, 1'b0},
    '{8'd11, 4'd0, 8'd0, 1'b0},   '{8'd13, 4'd0, 8'd12, 1'b1},   '{8'd100, 4'd0, 8'd13, 1'b1},
    '{8'd102, 4'd1, 8'd13, 1'b0}, '{8'd110, 4'd0, 8'd100, 1'b0}, '{8'd101, 4'd0, 8'd102, 1'b0},
    '{8'd99, 4'd2, 8'd110, 1'b0}, '{8'd20, 4'd0, 8'd101, 1'b0},  '{8'd30, 4'd0, 8'd99, 1'b0},
    '{8'd40, 4'd0, 8'd40, 1'b1},  '{8'd50, 4'd0, 8'd30, 1'b0},   '{8'd60, 4'd2, 8'd40, 1'b0},
    '{8'd70, 4'd0, 8'd50, 1'b0},  '{8'd80, 4'd3, 8'd60, 1'b0},   '{8'd90, 4'd0, 8'd70, 1'b0},
    '{8'd5, 4'd1, 8'd80, 1'b0},   '{8'd95, 4'd0, 8'd90, 1'b0},   '{8'd100, 4'd0, 8'd90, 1'b1}
  };

  logic                   clk;
  logic                   rst_n;
  sample_pkg::sample_t    sample_i;
  logic                   sample_valid_i;
  order_pkg::filter_out_t result_o;
  logic                   result_valid_o;
  int                     pass_count;
  int                     fail_count;
  int                     pending;
  int                     seed = 48;

  median_filter_top #(.SPREAD_MIN(SPREAD_MIN)) uut (.*);

  median_checker #(.SPREAD_MIN(SPREAD_MIN)) u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .result_i       (result_o),
    .result_valid_i (result_valid_o),
    .pass_count_o   (pass_count),
    .fail_count_o   (fail_count),
    .pending_o      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int idle_total();
    int sum;
    sum = 0;
    for (int i = 0; i < TABLE_LEN; i++)
      sum += int'(STIM[i].idle);
    return sum;
  endfunction

  task automatic drive_sample(input sample_pkg::sample_t value, input int idle);
    @(posedge clk);
    sample_i       <= value;
    sample_valid_i <= 1'b1;
    repeat (idle) begin
      @(posedge clk);
      sample_valid_i <= 1'b0;
    end
  endtask

  // Counts cycles once reset is released
  initial begin
    int cycles;
    int limit;
    cycles = 0;
    limit  = TABLE_LEN + RANDOM_COUNT + idle_total() + 64;
    while (cycles <= limit) begin
      @(posedge clk);
      if (rst_n)
        cycles++;
    end
    $display("Timeout after %0d cycles with %0d results still outstanding", limit, pending);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rst_n          = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < TABLE_LEN; i++) begin
      if (i >= sample_pkg::WINDOW_LEN - 1)
        u_checker.expect_result(STIM[i].want, STIM[i].replaced);
      drive_sample(STIM[i].sample, int'(STIM[i].idle));
    end
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      r = $random(seed);
      // Narrow band with repeats, now and then a full-range spike
      drive_sample((r[2:0] == 3'd0) ? r[15:8] : 8'd120 + {5'd0, r[18:16]}, 0);
    end
    @(posedge clk);
    sample_valid_i <= 1'b0;
    while (pending != 0)
      @(posedge clk);
    repeat (8) @(posedge clk);  // Catch stray strobes
    $display("Summary: %0d passed, %0d failed, %0d results expected",
             pass_count, fail_count, EXPECTED);
    if (fail_count == 0 && pass_count == EXPECTED)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/sample_pkg.sv
source/order_pkg.sv
source/sorting_network.sv
source/sort_ascending_5.sv
source/sample_window.sv
source/center_delay.sv
source/impulse_replace.sv
source/median_filter_top.sv
tb/median_checker.sv
tb/tb_median_filter.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_median_filter
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
